// ==== common/xgmii_pkg.sv ====
package xgmii_pkg;

    // XGMII control characters, valid only where the lane's rxc bit is set
    localparam logic [7:0] RS_IDLE  = 8'h07;
    localparam logic [7:0] RS_START = 8'hfb;
    localparam logic [7:0] RS_TERM  = 8'hfd;
    localparam logic [7:0] RS_ERROR = 8'hfe;

    // Ethernet CRC-32, reflected form
    localparam logic [31:0] CRC_POLY = 32'hedb88320;
    localparam logic [31:0] CRC_INIT = 32'hffffffff;

    // Register value after payload plus a correct FCS, no final inversion
    localparam logic [31:0] CRC_RESIDUE = 32'hdebb20e3;

    // Receive frame state
    typedef enum logic {
        RX_IDLE,
        RX_DATA
    } rx_state_t;

endpackage

// ==== hw/xgmii_rx_decode.sv ====
`timescale 1ns/1ps

module xgmii_rx_decode #(
    parameter int DATA_BYTES = 8
) (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic [8*DATA_BYTES-1:0] i_xgmii_rxd,
    input  logic [DATA_BYTES-1:0]   i_xgmii_rxc,
    input  logic                    i_phy_valid,
    output logic [8*DATA_BYTES-1:0] o_rxd,
    output logic                    o_valid,
    output logic [1:0]              o_start_loc,
    output logic [DATA_BYTES-1:0]   o_term_loc,
    output logic                    o_ctrl_err
);

    localparam int HALF = DATA_BYTES / 2;

    logic                  start_lo;
    logic                  start_hi;
    logic [DATA_BYTES-1:0] lane_term;
    logic [DATA_BYTES-1:0] lane_bad;

    // Start is only legal in lane 0 or the first lane of the upper half
    assign start_lo = i_xgmii_rxc[0] && (i_xgmii_rxd[7:0] == xgmii_pkg::RS_START);
    assign start_hi = i_xgmii_rxc[HALF]
                      && (i_xgmii_rxd[8*HALF +: 8] == xgmii_pkg::RS_START);

    always_comb begin
        for (int i = 0; i < DATA_BYTES; i++) begin
            lane_term[i] = i_xgmii_rxc[i]
                           && (i_xgmii_rxd[8*i +: 8] == xgmii_pkg::RS_TERM);
            // Any control code we do not expect inside a stream
            lane_bad[i]  = i_xgmii_rxc[i]
                           && (i_xgmii_rxd[8*i +: 8] != xgmii_pkg::RS_IDLE)
                           && (i_xgmii_rxd[8*i +: 8] != xgmii_pkg::RS_START)
                           && (i_xgmii_rxd[8*i +: 8] != xgmii_pkg::RS_TERM);
        end
    end

    always_ff @(posedge i_clk) begin
        o_rxd <= i_xgmii_rxd;
        if (i_reset) begin
            o_valid     <= 1'b0;
            o_start_loc <= 2'b00;
            o_term_loc  <= '0;
            o_ctrl_err  <= 1'b0;
        end else begin
            o_valid     <= i_phy_valid;
            // Bubbles carry no flags
            o_start_loc <= {start_hi, start_lo} & {2{i_phy_valid}};
            o_term_loc  <= lane_term & {DATA_BYTES{i_phy_valid}};
            o_ctrl_err  <= i_phy_valid && (|lane_bad);
        end
    end

endmodule

// ==== rx_mac/crc32_masked.sv ====
`timescale 1ns/1ps

module crc32_masked #(
    parameter int DATA_BYTES = 8
) (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic [8*DATA_BYTES-1:0] i_data,
    input  logic [DATA_BYTES-1:0]   i_byte_en,
    output logic [31:0]             o_crc_next,
    output logic [31:0]             o_crc
);

    // One byte through the reflected CRC, bit 0 first
    function automatic logic [31:0] crc_byte(
        input logic [31:0] crc,
        input logic [7:0]  data
    );
        logic [31:0] c;
        c = crc ^ {24'h000000, data};
        for (int b = 0; b < 8; b++) begin
            if (c[0]) begin
                c = (c >> 1) ^ xgmii_pkg::CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    // Lowest lane first, matching wire order
    always_comb begin
        o_crc_next = o_crc;
        for (int i = 0; i < DATA_BYTES; i++) begin
            if (i_byte_en[i]) begin
                o_crc_next = crc_byte(o_crc_next, i_data[8*i +: 8]);
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_crc <= xgmii_pkg::CRC_INIT;
        end else begin
            o_crc <= o_crc_next;
        end
    end

endmodule

// ==== rx_mac/rx_mac_framer.sv ====
`timescale 1ns/1ps

module rx_mac_framer #(
    parameter int DATA_BYTES = 8
) (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic [8*DATA_BYTES-1:0] i_rxd,
    input  logic                    i_valid,
    input  logic [1:0]              i_start_loc,
    input  logic [DATA_BYTES-1:0]   i_term_loc,
    input  logic                    i_ctrl_err,
    output logic [8*DATA_BYTES-1:0] o_data,
    output logic [DATA_BYTES-1:0]   o_keep,
    output logic                    o_valid,
    output logic                    o_last,
    output logic                    o_fcs_ok,
    output logic                    o_frame_err
);

    localparam int HALF = DATA_BYTES / 2;
    localparam logic [DATA_BYTES-1:0] UPPER_KEEP = {{(DATA_BYTES - HALF){1'b1}}, {HALF{1'b0}}};

    xgmii_pkg::rx_state_t rx_state;

    logic                    first_beat;
    logic                    start_hi;
    logic                    err_seen;
    logic                    beat;
    logic                    term;
    logic [DATA_BYTES-1:0]   keep;
    logic [8*DATA_BYTES-1:0] masked_data;
    logic                    crc_clear;
    logic [31:0]             crc_next;

    assign beat = (rx_state == xgmii_pkg::RX_DATA) && i_valid;
    assign term = |i_term_loc;

    // Keep mask and byte masking
    always_comb begin
        keep = '1;
        if (first_beat && start_hi) begin
            keep = UPPER_KEEP;
        end
        // One-hot minus one gives every lane below the terminate
        if (term) begin
            keep = keep & (i_term_loc - 1'b1);
        end
        for (int i = 0; i < DATA_BYTES; i++) begin
            masked_data[8*i +: 8] = keep[i] ? i_rxd[8*i +: 8] : 8'h00;
        end
    end

    // CRC runs over payload and FCS, held at init between frames
    assign crc_clear = i_reset || (rx_state == xgmii_pkg::RX_IDLE);

    crc32_masked #(
        .DATA_BYTES(DATA_BYTES)
    ) u_crc (
        .i_clk     (i_clk),
        .i_reset   (crc_clear),
        .i_data    (masked_data),
        .i_byte_en (keep & {DATA_BYTES{beat}}),
        .o_crc_next(crc_next),
        .o_crc     ()
    );

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            rx_state   <= xgmii_pkg::RX_IDLE;
            first_beat <= 1'b0;
            start_hi   <= 1'b0;
            err_seen   <= 1'b0;
        end else begin
            case (rx_state)
                xgmii_pkg::RX_IDLE: begin
                    if (|i_start_loc) begin
                        rx_state   <= xgmii_pkg::RX_DATA;
                        first_beat <= 1'b1;
                        start_hi   <= i_start_loc[1];
                        err_seen   <= 1'b0;
                    end
                end
                xgmii_pkg::RX_DATA: begin
                    if (beat) begin
                        first_beat <= 1'b0;
                        err_seen   <= err_seen || i_ctrl_err;
                        if (term) begin
                            rx_state <= xgmii_pkg::RX_IDLE;
                        end
                    end
                end
                default: rx_state <= xgmii_pkg::RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        o_data <= masked_data;
        o_keep <= keep;
        if (i_reset) begin
            o_valid     <= 1'b0;
            o_last      <= 1'b0;
            o_fcs_ok    <= 1'b0;
            o_frame_err <= 1'b0;
        end else begin
            o_valid     <= beat;
            o_last      <= beat && term;
            // Verdict includes this beat's bytes
            o_fcs_ok    <= beat && term && (crc_next == xgmii_pkg::CRC_RESIDUE);
            o_frame_err <= beat && term && (err_seen || i_ctrl_err);
        end
    end

endmodule

// ==== hw/rx_axis_out.sv ====
`timescale 1ns/1ps

module rx_axis_out #(
    parameter int DATA_BYTES = 8,
    parameter int CNT_WIDTH  = 16
) (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic [8*DATA_BYTES-1:0] i_data,
    input  logic [DATA_BYTES-1:0]   i_keep,
    input  logic                    i_valid,
    input  logic                    i_last,
    input  logic                    i_fcs_ok,
    input  logic                    i_frame_err,
    output logic [8*DATA_BYTES-1:0] o_axis_tdata,
    output logic [DATA_BYTES-1:0]   o_axis_tkeep,
    output logic                    o_axis_tvalid,
    output logic                    o_axis_tlast,
    output logic                    o_axis_tuser,
    output logic [CNT_WIDTH-1:0]    o_frame_count,
    output logic [CNT_WIDTH-1:0]    o_fcs_err_count
);

    logic frame_end;
    logic frame_good;

    assign frame_end  = i_valid && i_last;
    assign frame_good = i_fcs_ok && !i_frame_err;

    always_ff @(posedge i_clk) begin
        o_axis_tdata <= i_data;
        o_axis_tkeep <= i_keep;
        if (i_reset) begin
            o_axis_tvalid   <= 1'b0;
            o_axis_tlast    <= 1'b0;
            o_axis_tuser    <= 1'b0;
            o_frame_count   <= '0;
            o_fcs_err_count <= '0;
        end else begin
            o_axis_tvalid <= i_valid;
            o_axis_tlast  <= frame_end;
            // tuser only carries meaning on the last beat
            o_axis_tuser  <= frame_end && frame_good;
            // Counters wrap at CNT_WIDTH
            if (frame_end) begin
                o_frame_count <= o_frame_count + 1'b1;
                if (!frame_good) begin
                    o_fcs_err_count <= o_fcs_err_count + 1'b1;
                end
            end
        end
    end

endmodule

// ==== hw/xgmii_rx_top.sv ====
`timescale 1ns/1ps

module xgmii_rx_top #(
    parameter int DATA_BYTES = 8,
    parameter int CNT_WIDTH  = 16
) (
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic [8*DATA_BYTES-1:0] i_xgmii_rxd,
    input  logic [DATA_BYTES-1:0]   i_xgmii_rxc,
    input  logic                    i_phy_valid,
    output logic [8*DATA_BYTES-1:0] o_axis_tdata,
    output logic [DATA_BYTES-1:0]   o_axis_tkeep,
    output logic                    o_axis_tvalid,
    output logic                    o_axis_tlast,
    output logic                    o_axis_tuser,
    output logic [CNT_WIDTH-1:0]    o_frame_count,
    output logic [CNT_WIDTH-1:0]    o_fcs_err_count
);

    // Decode to framer
    logic [8*DATA_BYTES-1:0] dec_rxd;
    logic                    dec_valid;
    logic [1:0]              dec_start_loc;
    logic [DATA_BYTES-1:0]   dec_term_loc;
    logic                    dec_ctrl_err;

    // Framer to output stage
    logic [8*DATA_BYTES-1:0] frm_data;
    logic [DATA_BYTES-1:0]   frm_keep;
    logic                    frm_valid;
    logic                    frm_last;
    logic                    frm_fcs_ok;
    logic                    frm_frame_err;

    xgmii_rx_decode #(
        .DATA_BYTES(DATA_BYTES)
    ) u_decode (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_xgmii_rxd(i_xgmii_rxd),
        .i_xgmii_rxc(i_xgmii_rxc),
        .i_phy_valid(i_phy_valid),
        .o_rxd      (dec_rxd),
        .o_valid    (dec_valid),
        .o_start_loc(dec_start_loc),
        .o_term_loc (dec_term_loc),
        .o_ctrl_err (dec_ctrl_err)
    );

    rx_mac_framer #(
        .DATA_BYTES(DATA_BYTES)
    ) u_framer (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_rxd      (dec_rxd),
        .i_valid    (dec_valid),
        .i_start_loc(dec_start_loc),
        .i_term_loc (dec_term_loc),
        .i_ctrl_err (dec_ctrl_err),
        .o_data     (frm_data),
        .o_keep     (frm_keep),
        .o_valid    (frm_valid),
        .o_last     (frm_last),
        .o_fcs_ok   (frm_fcs_ok),
        .o_frame_err(frm_frame_err)
    );

    rx_axis_out #(
        .DATA_BYTES(DATA_BYTES),
        .CNT_WIDTH (CNT_WIDTH)
    ) u_out (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_data         (frm_data),
        .i_keep         (frm_keep),
        .i_valid        (frm_valid),
        .i_last         (frm_last),
        .i_fcs_ok       (frm_fcs_ok),
        .i_frame_err    (frm_frame_err),
        .o_axis_tdata   (o_axis_tdata),
        .o_axis_tkeep   (o_axis_tkeep),
        .o_axis_tvalid  (o_axis_tvalid),
        .o_axis_tlast   (o_axis_tlast),
        .o_axis_tuser   (o_axis_tuser),
        .o_frame_count  (o_frame_count),
        .o_fcs_err_count(o_fcs_err_count)
    );

endmodule

// ==== verification/xgmii_rx_props.sv ====
`timescale 1ns/1ps

module xgmii_rx_props #(
    parameter int CNT_WIDTH = 16
) (
    input logic                 i_clk,
    input logic                 i_reset,
    input logic                 i_tvalid,
    input logic                 i_tlast,
    input logic                 i_tuser,
    input logic [CNT_WIDTH-1:0] i_frame_count,
    input logic [CNT_WIDTH-1:0] i_fcs_err_count
);

    tlast_needs_tvalid: assert property (@(posedge i_clk) disable iff (i_reset)
        i_tlast |-> i_tvalid)
        else $error("tlast high without tvalid");

    tuser_needs_tvalid: assert property (@(posedge i_clk) disable iff (i_reset)
        i_tuser |-> i_tvalid)
        else $error("tuser high without tvalid");

    // Counters move together with the last beat leaving the block
    frame_count_on_last: assert property (@(posedge i_clk) disable iff (i_reset)
        !$stable(i_frame_count) |-> i_tlast)
        else $error("frame counter changed without a last beat");

    // Only a bad frame may bump the error counter
    err_count_on_bad_last: assert property (@(posedge i_clk) disable iff (i_reset)
        !$stable(i_fcs_err_count) |-> (i_tlast && !i_tuser))
        else $error("FCS error counter changed without a bad last beat");

endmodule

bind rx_axis_out xgmii_rx_props #(
    .CNT_WIDTH(CNT_WIDTH)
) u_props (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_tvalid       (o_axis_tvalid),
    .i_tlast        (o_axis_tlast),
    .i_tuser        (o_axis_tuser),
    .i_frame_count  (o_frame_count),
    .i_fcs_err_count(o_fcs_err_count)
);

// ==== verification/tb_xgmii_rx.sv ====
`timescale 1ns/1ps

module tb_xgmii_rx;

    localparam int DATA_BYTES   = 8;
    localparam int CNT_WIDTH    = 16;
    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int LATENCY      = 3;
    localparam string VEC_FILE  = "verification/xgmii_rx_vectors.txt";

    logic                    i_clk;
    logic                    i_reset;
    logic [8*DATA_BYTES-1:0] i_xgmii_rxd;
    logic [DATA_BYTES-1:0]   i_xgmii_rxc;
    logic                    i_phy_valid;
    logic [8*DATA_BYTES-1:0] o_axis_tdata;
    logic [DATA_BYTES-1:0]   o_axis_tkeep;
    logic                    o_axis_tvalid;
    logic                    o_axis_tlast;
    logic                    o_axis_tuser;
    logic [CNT_WIDTH-1:0]    o_frame_count;
    logic [CNT_WIDTH-1:0]    o_fcs_err_count;

    // One entry per vector line
    logic [63:0] vec_rxd[$];
    logic [7:0]  vec_rxc[$];
    logic        vec_pv[$];
    logic        exp_valid[$];
    logic [7:0]  exp_keep[$];
    logic [63:0] exp_data[$];
    logic        exp_last[$];
    logic        exp_user[$];

    int mismatch_count;
    int other_errors;
    int check_count;
    int num_vec;
    int exp_frames;
    int exp_bad_frames;
    int seed;
    bit vec_loaded;

    xgmii_rx_top #(
        .DATA_BYTES(DATA_BYTES),
        .CNT_WIDTH (CNT_WIDTH)
    ) dut0 (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_xgmii_rxd    (i_xgmii_rxd),
        .i_xgmii_rxc    (i_xgmii_rxc),
        .i_phy_valid    (i_phy_valid),
        .o_axis_tdata   (o_axis_tdata),
        .o_axis_tkeep   (o_axis_tkeep),
        .o_axis_tvalid  (o_axis_tvalid),
        .o_axis_tlast   (o_axis_tlast),
        .o_axis_tuser   (o_axis_tuser),
        .o_frame_count  (o_frame_count),
        .o_fcs_err_count(o_fcs_err_count)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    task automatic parse_line(input string line);
        logic [63:0] rxd;
        logic [63:0] data;
        logic [7:0]  rxc;
        logic [7:0]  keep;
        logic        pv;
        logic        ev;
        logic        el;
        logic        eu;
        int          n;
        if (line.len() < 8 || line.substr(0, 0) == "#") begin
            return;
        end
        n = $sscanf(line, "%h %h %h %h %h %h %h %h", rxd, rxc, pv, ev, keep, data, el, eu);
        if (n != 8) begin
            $display("Malformed line in vector file: %s", line);
            other_errors++;
        end else begin
            vec_rxd.push_back(rxd);
            vec_rxc.push_back(rxc);
            vec_pv.push_back(pv);
            exp_valid.push_back(ev);
            exp_keep.push_back(keep);
            exp_data.push_back(data);
            exp_last.push_back(el);
            exp_user.push_back(eu);
            // Counter expectations follow from the last beats
            if (ev && el) begin
                exp_frames++;
                if (!eu) begin
                    exp_bad_frames++;
                end
            end
        end
    endtask

    task automatic load_vectors();
        int    fd;
        int    n;
        string line;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the vector file %s", VEC_FILE);
            other_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0) begin
                    parse_line(line);
                end
            end
            $fclose(fd);
            if (vec_rxd.size() == 0) begin
                $display("The vector file holds no vectors");
                other_errors++;
            end
        end
        num_vec = vec_rxd.size();
    endtask

    task automatic drive_word(input logic [63:0] rxd, input logic [7:0] rxc, input logic pv);
        i_xgmii_rxd <= rxd;
        i_xgmii_rxc <= rxc;
        i_phy_valid <= pv;
    endtask

    task automatic apply_vector(input int idx);
        logic [63:0] rxd;
        logic [31:0] junk;
        logic [7:0]  rxc;
        rxd = vec_rxd[idx];
        rxc = vec_rxc[idx];
        // Bubbles get junk so the pipeline has to ignore their content
        if (!vec_pv[idx]) begin
            rxd  = {$random(seed), $random(seed)};
            junk = $random(seed);
            rxc  = junk[7:0];
        end
        drive_word(rxd, rxc, vec_pv[idx]);
    endtask

    task automatic check_beat(input int idx);
        check_count++;
        if (o_axis_tvalid !== exp_valid[idx]) begin
            $display("CHECK FAILED @ %0t ns: vector %0d tvalid %0b, expected %0b",
                     $time, idx, o_axis_tvalid, exp_valid[idx]);
            mismatch_count++;
        end
        if (o_axis_tlast !== exp_last[idx]) begin
            $display("CHECK FAILED @ %0t ns: vector %0d tlast %0b, expected %0b",
                     $time, idx, o_axis_tlast, exp_last[idx]);
            mismatch_count++;
        end
        if (o_axis_tuser !== exp_user[idx]) begin
            $display("CHECK FAILED @ %0t ns: vector %0d tuser %0b, expected %0b",
                     $time, idx, o_axis_tuser, exp_user[idx]);
            mismatch_count++;
        end
        // Keep and data only mean something on a valid beat
        if (exp_valid[idx]) begin
            if (o_axis_tkeep !== exp_keep[idx]) begin
                $display("CHECK FAILED @ %0t ns: vector %0d tkeep %02h, expected %02h",
                         $time, idx, o_axis_tkeep, exp_keep[idx]);
                mismatch_count++;
            end
            if (o_axis_tdata !== exp_data[idx]) begin
                $display("CHECK FAILED @ %0t ns: vector %0d tdata %016h, expected %016h",
                         $time, idx, o_axis_tdata, exp_data[idx]);
                mismatch_count++;
            end
        end
    endtask

    task automatic check_counters(input int frames, input int bad_frames);
        check_count++;
        if (o_frame_count !== CNT_WIDTH'(frames)) begin
            $display("CHECK FAILED @ %0t ns: frame count %0d, expected %0d",
                     $time, o_frame_count, frames);
            mismatch_count++;
        end
        if (o_fcs_err_count !== CNT_WIDTH'(bad_frames)) begin
            $display("CHECK FAILED @ %0t ns: FCS error count %0d, expected %0d",
                     $time, o_fcs_err_count, bad_frames);
            mismatch_count++;
        end
    endtask

    task automatic report_summary();
        $display("Summary: %0d checks, %0d mismatches, %0d other failures",
                 check_count, mismatch_count, other_errors);
    endtask

    initial begin
        seed           = 32'h1f06_d5f5;
        mismatch_count = 0;
        other_errors   = 0;
        check_count    = 0;
        exp_frames     = 0;
        exp_bad_frames = 0;
        vec_loaded     = 1'b0;
        i_reset        = 1'b1;
        i_xgmii_rxd    = 64'h0707070707070707;
        i_xgmii_rxc    = 8'hff;
        i_phy_valid    = 1'b0;
        load_vectors();
        vec_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge i_clk);
        i_reset <= 1'b0;
        @(negedge i_clk);
        // Stream quiet and counters cleared out of reset
        if (o_axis_tvalid !== 1'b0 || o_axis_tlast !== 1'b0 || o_axis_tuser !== 1'b0) begin
            $display("CHECK FAILED @ %0t ns: stream not idle after reset", $time);
            mismatch_count++;
        end
        check_counters(0, 0);
        for (int c = 0; c < num_vec + LATENCY; c++) begin
            @(posedge i_clk);
            if (c < num_vec) begin
                apply_vector(c);
            end else begin
                drive_word(64'h0707070707070707, 8'hff, 1'b1);
            end
            @(negedge i_clk);
            if (c >= LATENCY) begin
                check_beat(c - LATENCY);
            end
        end
        check_counters(exp_frames, exp_bad_frames);
        report_summary();
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Watchdog sized from the vector count
    initial begin
        int limit_cycles;
        wait (vec_loaded);
        limit_cycles = num_vec + RESET_CYCLES + 20;
        #(limit_cycles * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", limit_cycles);
        other_errors++;
        report_summary();
        $display("Errors found");
        $finish;
    end

endmodule

// ==== verification/xgmii_rx_vectors.txt ====
# rxd rxc phy_valid, then expected tvalid tkeep tdata tlast tuser (all hex)
# expected columns give the stream output three cycles after the word is driven
0707070707070707 ff 1 0 00 0000000000000000 0 0
0707070707070707 ff 1 0 00 0000000000000000 0 0
# lane 0 start, payload "123456789", good FCS, terminate lane 5
d5555555555555fb 01 1 0 00 0000000000000000 0 0
3837363534333231 00 1 1 ff 3837363534333231 0 0
0707fdcbf4392639 e0 1 1 1f 000000cbf4392639 1 1
0707070707070707 ff 1 0 00 0000000000000000 0 0
# lane 4 start, empty payload, terminate lane 0
555555fb07070707 1f 1 0 00 0000000000000000 0 0
00000000d5555555 00 1 1 f0 0000000000000000 0 0
07070707070707fd ff 1 1 00 0000000000000000 1 1
0707070707070707 ff 1 0 00 0000000000000000 0 0
# lane 4 start, payload "a", terminate lane 1
555555fb07070707 1f 1 0 00 0000000000000000 0 0
b7be4361d5555555 00 1 1 f0 b7be436100000000 0 0
070707070707fde8 fe 1 1 01 00000000000000e8 1 1
0707070707070707 ff 1 0 00 0000000000000000 0 0
# lane 4 start, payload ff ff, terminate lane 2
555555fb07070707 1f 1 0 00 0000000000000000 0 0
0000ffffd5555555 00 1 1 f0 0000ffff00000000 0 0
0707070707fdffff fc 1 1 03 000000000000ffff 1 1
0707070707070707 ff 1 0 00 0000000000000000 0 0
# lane 4 start, payload "abc", terminate lane 3
555555fb07070707 1f 1 0 00 0000000000000000 0 0
c2636261d5555555 00 1 1 f0 c263626100000000 0 0
07070707fd352441 f8 1 1 07 0000000000352441 1 1
0707070707070707 ff 1 0 00 0000000000000000 0 0
0707070707070707 ff 0 0 00 0000000000000000 0 0
# lane 0 start, empty payload, terminate lane 4
d5555555555555fb 01 1 0 00 0000000000000000 0 0
070707fd00000000 f0 1 1 0f 0000000000000000 1 1
0707070707070707 ff 1 0 00 0000000000000000 0 0
# lane 0 start, payload ff ff, terminate lane 6
d5555555555555fb 01 1 0 00 0000000000000000 0 0
07fdffff0000ffff c0 1 1 3f 0000ffff0000ffff 1 1
0707070707070707 ff 1 0 00 0000000000000000 0 0
# lane 0 start, payload "abc", terminate lane 7
d5555555555555fb 01 1 0 00 0000000000000000 0 0
fd352441c2636261 80 1 1 7f 00352441c2636261 1 1
0707070707070707 ff 1 0 00 0000000000000000 0 0
# corrupted FCS byte
d5555555555555fb 01 1 0 00 0000000000000000 0 0
3837363534333231 00 1 1 ff 3837363534333231 0 0
0707fdcbf4392739 e0 1 1 1f 000000cbf4392739 1 0
0707070707070707 ff 1 0 00 0000000000000000 0 0
# error control character in lane 4
d5555555555555fb 01 1 0 00 0000000000000000 0 0
383736fe34333231 10 1 1 ff 383736fe34333231 0 0
0707fdcbf4392639 e0 1 1 1f 000000cbf4392639 1 0
0707070707070707 ff 1 0 00 0000000000000000 0 0
# good frame with bubbles inside
d5555555555555fb 01 1 0 00 0000000000000000 0 0
0000000000000000 00 0 0 00 0000000000000000 0 0
3837363534333231 00 1 1 ff 3837363534333231 0 0
0000000000000000 00 0 0 00 0000000000000000 0 0
0000000000000000 00 0 0 00 0000000000000000 0 0
0707fdcbf4392639 e0 1 1 1f 000000cbf4392639 1 1
0707070707070707 ff 1 0 00 0000000000000000 0 0
0707070707070707 ff 1 0 00 0000000000000000 0 0

// ==== xgmii_rx.f ====
common/xgmii_pkg.sv
hw/xgmii_rx_decode.sv
rx_mac/crc32_masked.sv
rx_mac/rx_mac_framer.sv
hw/rx_axis_out.sv
hw/xgmii_rx_top.sv
verification/xgmii_rx_props.sv
verification/tb_xgmii_rx.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the XGMII receive testbench with Verilator
set -euo pipefail

cd "$(dirname "$0")"

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module tb_xgmii_rx \
    -Mdir "$BUILD_DIR" \
    -f xgmii_rx.f

"./$BUILD_DIR/Vtb_xgmii_rx" | tee "$LOG"

if grep -q "Errors found" "$LOG"; then
    echo "Simulation failed, see $LOG"
    exit 1
fi
echo "Simulation passed"
